// ==== hdl/rv_core_pkg.sv ====
package rv_core_pkg;

  // basic widths
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [2:0]  alu_op_t;

  // alu operation codes
  localparam alu_op_t ALU_ADD    = 3'd0;
  localparam alu_op_t ALU_SUB    = 3'd1;
  localparam alu_op_t ALU_AND    = 3'd2;
  localparam alu_op_t ALU_OR     = 3'd3;
  localparam alu_op_t ALU_XOR    = 3'd4;
  localparam alu_op_t ALU_PASS_B = 3'd5;

  // fetch start after reset and halt
  localparam word_t RESET_PC = 32'h0000_0100;

  // rv32i major opcodes in use
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;

  typedef struct packed {
    word_t addr;
    logic  ren;
  } ibus_req_t;

  typedef struct packed {
    logic  busy;
    word_t rdata;
  } ibus_rsp_t;

  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t pc4;
    word_t instr;
    logic  mal_insn;
  } fetch_decode_t;

  typedef struct packed {
    logic      valid;
    word_t     pc;
    word_t     pc4;
    alu_op_t   alu_op;
    word_t     rs1_val;
    word_t     rs2_val;
    word_t     imm;
    reg_addr_t rd;
    logic      use_imm;
    logic      is_branch;
    logic      branch_ne;
    logic      is_jal;
    logic      writes_rd;
    logic      mal_insn;
  } decode_execute_t;

  typedef struct packed {
    logic  valid;
    word_t target;
  } redirect_t;

  typedef struct packed {
    logic      we;
    reg_addr_t rd;
    word_t     value;
  } wb_t;

  typedef struct packed {
    logic      valid;
    word_t     pc;
    reg_addr_t rd;
    word_t     value;
  } retire_t;

  typedef enum logic {
    RUN,
    FAULT
  } core_state_e;

endpackage

// ==== hdl/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage (
  input  logic                       CLK,
  input  logic                       nRST,
  input  logic                       halt,
  input  rv_core_pkg::redirect_t     redirect,
  output rv_core_pkg::ibus_req_t     ibus_req,
  input  rv_core_pkg::ibus_rsp_t     ibus_rsp,
  output rv_core_pkg::fetch_decode_t fetch_out
);

  rv_core_pkg::word_t pc_q;
  rv_core_pkg::word_t pc4;
  logic               fetch_done;
  logic               mal_addr;

  // sequential next address
  assign pc4 = pc_q + 32'd4;

  // word fetches only, low bits must be zero
  assign mal_addr = (pc_q[1:0] != 2'b00);

  // request comes straight off the pc flop
  assign ibus_req.addr = pc_q;
  assign ibus_req.ren  = ~halt;

  // handshake done when requesting and memory not busy
  assign fetch_done = ibus_req.ren & ~ibus_rsp.busy;

  // program counter
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc_q <= rv_core_pkg::RESET_PC;
    end else if (halt) begin
      // park at the start address
      pc_q <= rv_core_pkg::RESET_PC;
    end else if (redirect.valid) begin
      // taken branch or jal from execute
      pc_q <= redirect.target;
    end else if (fetch_done) begin
      pc_q <= pc4;
    end
    // busy with no redirect: hold
  end

  // fetch/decode latch
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      fetch_out <= '0;
    end else if (halt || redirect.valid || !fetch_done) begin
      // bubble, payload left as is
      fetch_out.valid <= 1'b0;
    end else begin
      fetch_out.valid    <= 1'b1;
      fetch_out.pc       <= pc_q;
      fetch_out.pc4      <= pc4;
      // bus words arrive little-endian, no swap
      fetch_out.instr    <= ibus_rsp.rdata;
      fetch_out.mal_insn <= mal_addr;
    end
  end

  // address must not move while memory is stalling us
  property p_addr_stable_on_busy;
    @(posedge CLK) disable iff (!nRST)
      (ibus_rsp.busy && !redirect.valid && !halt) |=> $stable(ibus_req.addr);
  endproperty
  a_addr_stable_on_busy: assert property (p_addr_stable_on_busy)
    else $error("fetch address changed under busy");

endmodule

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
  input  logic                         CLK,
  input  logic                         nRST,
  input  logic                         halt,
  input  logic                         flush,
  input  rv_core_pkg::fetch_decode_t   fetch_in,
  output rv_core_pkg::reg_addr_t       rs1_addr,
  output rv_core_pkg::reg_addr_t       rs2_addr,
  input  rv_core_pkg::word_t           rs1_data,
  input  rv_core_pkg::word_t           rs2_data,
  output rv_core_pkg::decode_execute_t decode_out
);

  rv_core_pkg::decode_execute_t dec;
  rv_core_pkg::word_t           instr;
  logic [6:0]                   opcode;
  logic [2:0]                   funct3;
  logic [6:0]                   funct7;
  logic                         known;

  assign instr  = fetch_in.instr;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // register file read ports, always from the raw fields
  assign rs1_addr = instr[19:15];
  assign rs2_addr = instr[24:20];

  always_comb begin
    dec       = '0;
    known     = 1'b0;
    dec.pc       = fetch_in.pc;
    dec.pc4      = fetch_in.pc4;
    dec.rs1_val  = rs1_data;
    dec.rs2_val  = rs2_data;
    dec.rd       = instr[11:7];
    dec.mal_insn = fetch_in.mal_insn;
    case (opcode)
      rv_core_pkg::OP_REG: begin
        known         = 1'b1;
        dec.writes_rd = 1'b1;
        case (funct3)
          3'b000:  dec.alu_op = funct7[5] ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
          3'b111:  dec.alu_op = rv_core_pkg::ALU_AND;
          3'b110:  dec.alu_op = rv_core_pkg::ALU_OR;
          3'b100:  dec.alu_op = rv_core_pkg::ALU_XOR;
          default: known = 1'b0;
        endcase
      end
      rv_core_pkg::OP_IMM: begin
        // only addi is supported
        known         = (funct3 == 3'b000);
        dec.writes_rd = 1'b1;
        dec.use_imm   = 1'b1;
        dec.alu_op    = rv_core_pkg::ALU_ADD;
        dec.imm       = {{20{instr[31]}}, instr[31:20]};
      end
      rv_core_pkg::OP_LUI: begin
        known         = 1'b1;
        dec.writes_rd = 1'b1;
        dec.use_imm   = 1'b1;
        dec.alu_op    = rv_core_pkg::ALU_PASS_B;
        dec.imm       = {instr[31:12], 12'b0};
      end
      rv_core_pkg::OP_BRANCH: begin
        // beq and bne only
        known         = (funct3 == 3'b000) || (funct3 == 3'b001);
        dec.is_branch = 1'b1;
        dec.branch_ne = funct3[0];
        dec.imm       = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                         instr[11:8], 1'b0};
      end
      rv_core_pkg::OP_JAL: begin
        // link write handled in execute off is_jal
        known      = 1'b1;
        dec.is_jal = 1'b1;
        dec.imm    = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                      instr[30:21], 1'b0};
      end
      default: known = 1'b0;
    endcase
    // misaligned fetch: strip all control, keep only the flag
    if (fetch_in.mal_insn) begin
      dec.writes_rd = 1'b0;
      dec.is_branch = 1'b0;
      dec.is_jal    = 1'b0;
    end
    // unknown opcode becomes a bubble
    dec.valid = fetch_in.valid & (known | fetch_in.mal_insn);
  end

  // decode/execute latch
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      decode_out <= '0;
    end else if (halt || flush) begin
      decode_out.valid <= 1'b0;
    end else begin
      decode_out <= dec;
    end
  end

  // one kind of work per valid instruction
  property p_one_kind;
    @(posedge CLK) disable iff (!nRST)
      (decode_out.valid && !decode_out.mal_insn) |->
        $onehot({decode_out.is_branch, decode_out.is_jal, decode_out.writes_rd});
  endproperty
  a_one_kind: assert property (p_one_kind)
    else $error("decoded instruction has no single kind");

endmodule

// ==== hdl/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
  input  logic                         CLK,
  input  logic                         nRST,
  input  logic                         halt,
  input  rv_core_pkg::decode_execute_t exec_in,
  output rv_core_pkg::redirect_t       redirect,
  output rv_core_pkg::wb_t             wb,
  output rv_core_pkg::retire_t         retire,
  output logic                         fault
);

  rv_core_pkg::core_state_e state_q;
  rv_core_pkg::word_t       op_b;
  rv_core_pkg::word_t       alu_y;
  logic                     live;
  logic                     taken;
  logic                     writes;

  // instruction actually executes this cycle
  assign live = exec_in.valid & ~exec_in.mal_insn & ~halt &
                (state_q == rv_core_pkg::RUN);

  assign op_b = exec_in.use_imm ? exec_in.imm : exec_in.rs2_val;

  always_comb begin
    case (exec_in.alu_op)
      rv_core_pkg::ALU_ADD:    alu_y = exec_in.rs1_val + op_b;
      rv_core_pkg::ALU_SUB:    alu_y = exec_in.rs1_val - op_b;
      rv_core_pkg::ALU_AND:    alu_y = exec_in.rs1_val & op_b;
      rv_core_pkg::ALU_OR:     alu_y = exec_in.rs1_val | op_b;
      rv_core_pkg::ALU_XOR:    alu_y = exec_in.rs1_val ^ op_b;
      rv_core_pkg::ALU_PASS_B: alu_y = op_b;
      default:                 alu_y = '0;
    endcase
  end

  // beq when equal, bne when not
  assign taken = exec_in.is_branch &
                 ((exec_in.rs1_val == exec_in.rs2_val) ^ exec_in.branch_ne);

  // pc-relative target, not-taken assumed by fetch
  assign redirect.valid  = live & (taken | exec_in.is_jal);
  assign redirect.target = exec_in.pc + exec_in.imm;

  // jal links pc4, x0 never written
  assign writes   = live & (exec_in.writes_rd | exec_in.is_jal);
  assign wb.we    = writes & (exec_in.rd != 5'd0);
  assign wb.rd    = exec_in.rd;
  assign wb.value = exec_in.is_jal ? exec_in.pc4 : alu_y;

  // retire report, one cycle behind execute
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      retire <= '0;
    end else begin
      retire.valid <= live;
      retire.pc    <= exec_in.pc;
      retire.rd    <= exec_in.rd;
      retire.value <= wb.we ? wb.value : '0;
    end
  end

  // fault fsm
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state_q <= rv_core_pkg::RUN;
    end else if (halt) begin
      state_q <= rv_core_pkg::RUN;
    end else if (exec_in.valid && exec_in.mal_insn) begin
      // sticky until reset or halt
      state_q <= rv_core_pkg::FAULT;
    end
  end

  assign fault = (state_q == rv_core_pkg::FAULT);

  // nothing retires once faulted
  a_no_retire_in_fault: assert property (
    @(posedge CLK) disable iff (!nRST) fault |-> !retire.valid)
    else $error("retire while in fault state");

  // redirect only from a real instruction
  a_redirect_source: assert property (
    @(posedge CLK) disable iff (!nRST) redirect.valid |-> exec_in.valid && !exec_in.mal_insn)
    else $error("redirect without a valid instruction");

endmodule

// ==== hdl/register_file.sv ====
`timescale 1ns/1ps

module register_file (
  input  logic                   CLK,
  input  logic                   nRST,
  input  rv_core_pkg::wb_t       wb,
  input  rv_core_pkg::reg_addr_t rs1_addr,
  input  rv_core_pkg::reg_addr_t rs2_addr,
  output rv_core_pkg::word_t     rs1_data,
  output rv_core_pkg::word_t     rs2_data
);

  rv_core_pkg::word_t regs [32];

  // x0 writes are dropped in execute, entry 0 keeps its reset value
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.we) begin
      regs[wb.rd] <= wb.value;
    end
  end

  // x0 reads zero, same-cycle write forwarded to decode
  always_comb begin
    if (rs1_addr == 5'd0) begin
      rs1_data = '0;
    end else if (wb.we && (wb.rd == rs1_addr)) begin
      rs1_data = wb.value;
    end else begin
      rs1_data = regs[rs1_addr];
    end
    if (rs2_addr == 5'd0) begin
      rs2_data = '0;
    end else if (wb.we && (wb.rd == rs2_addr)) begin
      rs2_data = wb.value;
    end else begin
      rs2_data = regs[rs2_addr];
    end
  end

  a_x0_fixed: assert property (@(posedge CLK) disable iff (!nRST) regs[0] == '0)
    else $error("x0 storage changed");

endmodule

// ==== hdl/core_top.sv ====
`timescale 1ns/1ps

module core_top (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   halt,
  output rv_core_pkg::ibus_req_t ibus_req,
  input  rv_core_pkg::ibus_rsp_t ibus_rsp,
  output rv_core_pkg::retire_t   retire,
  output logic                   fault
);

  // stage to stage
  rv_core_pkg::fetch_decode_t   fetch_decode;
  rv_core_pkg::decode_execute_t decode_execute;
  rv_core_pkg::redirect_t       redirect;
  rv_core_pkg::wb_t             wb;

  // register file ports
  rv_core_pkg::reg_addr_t rs1_addr;
  rv_core_pkg::reg_addr_t rs2_addr;
  rv_core_pkg::word_t     rs1_data;
  rv_core_pkg::word_t     rs2_data;

  fetch_stage fetch_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .halt      (halt),
    .redirect  (redirect),
    .ibus_req  (ibus_req),
    .ibus_rsp  (ibus_rsp),
    .fetch_out (fetch_decode)
  );

  // redirect doubles as the decode flush
  decode_stage decode_i (
    .CLK        (CLK),
    .nRST       (nRST),
    .halt       (halt),
    .flush      (redirect.valid),
    .fetch_in   (fetch_decode),
    .rs1_addr   (rs1_addr),
    .rs2_addr   (rs2_addr),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .decode_out (decode_execute)
  );

  execute_stage execute_i (
    .CLK      (CLK),
    .nRST     (nRST),
    .halt     (halt),
    .exec_in  (decode_execute),
    .redirect (redirect),
    .wb       (wb),
    .retire   (retire),
    .fault    (fault)
  );

  register_file regfile_i (
    .CLK      (CLK),
    .nRST     (nRST),
    .wb       (wb),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

endmodule

// ==== bench/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen (
  output logic CLK,
  output logic nRST
);

  // 10 ns period
  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // reset held over three rising edges, released just after the third
  initial begin
    nRST = 1'b0;
    repeat (3) @(posedge CLK);
    #1;
    nRST = 1'b1;
  end

endmodule

// ==== bench/instr_mem_model.sv ====
`timescale 1ns/1ps

module instr_mem_model (
  input  logic                   CLK,
  input  logic                   nRST,
  input  rv_core_pkg::ibus_req_t ibus_req,
  output rv_core_pkg::ibus_rsp_t ibus_rsp
);

  rv_core_pkg::word_t rom [32];
  rv_core_pkg::word_t rdata;
  logic [31:0]        lcg_state = 32'he9f2_96de;
  logic               busy_q = 1'b0;

  // rv32i encoders
  function automatic rv_core_pkg::word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
      input rv_core_pkg::reg_addr_t rd, input rv_core_pkg::reg_addr_t rs1,
      input rv_core_pkg::reg_addr_t rs2);
    return {f7, rs2, rs1, f3, rd, rv_core_pkg::OP_REG};
  endfunction

  function automatic rv_core_pkg::word_t enc_i(input rv_core_pkg::reg_addr_t rd,
      input rv_core_pkg::reg_addr_t rs1, input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, rv_core_pkg::OP_IMM};
  endfunction

  function automatic rv_core_pkg::word_t enc_u(input rv_core_pkg::reg_addr_t rd,
      input logic [19:0] imm);
    return {imm, rd, rv_core_pkg::OP_LUI};
  endfunction

  function automatic rv_core_pkg::word_t enc_b(input logic [2:0] f3,
      input rv_core_pkg::reg_addr_t rs1, input rv_core_pkg::reg_addr_t rs2,
      input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_core_pkg::OP_BRANCH};
  endfunction

  function automatic rv_core_pkg::word_t enc_j(input rv_core_pkg::reg_addr_t rd,
      input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_core_pkg::OP_JAL};
  endfunction

  // harmless addi x0 whose immediate folds in every address bit
  function automatic rv_core_pkg::word_t fill_word(input rv_core_pkg::word_t addr);
    return {addr[11:0] ^ addr[23:12] ^ {4'h0, addr[31:24]}, 5'd0, 3'b000, 5'd0,
            rv_core_pkg::OP_IMM};
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  initial begin
    rom[0]  = enc_u(5'd1, 20'h12345);
    rom[1]  = enc_i(5'd2, 5'd0, 12'h678);
    rom[2]  = enc_r(7'b0000000, 3'b000, 5'd3, 5'd1, 5'd2);
    rom[3]  = enc_i(5'd4, 5'd0, 12'hfff);
    rom[4]  = enc_r(7'b0000000, 3'b100, 5'd5, 5'd3, 5'd4);
    rom[5]  = enc_r(7'b0000000, 3'b111, 5'd6, 5'd3, 5'd2);
    rom[6]  = enc_r(7'b0000000, 3'b110, 5'd7, 5'd1, 5'd2);
    rom[7]  = enc_r(7'b0100000, 3'b000, 5'd8, 5'd2, 5'd3);
    // write to x0 must be dropped
    rom[8]  = enc_r(7'b0000000, 3'b000, 5'd0, 5'd1, 5'd2);
    rom[9]  = enc_r(7'b0000000, 3'b000, 5'd9, 5'd0, 5'd1);
    // beq taken to 0x134
    rom[10] = enc_b(3'b000, 5'd2, 5'd6, 13'd12);
    rom[11] = enc_i(5'd10, 5'd0, 12'h111);
    rom[12] = enc_i(5'd11, 5'd0, 12'h222);
    // bne with equal operands, falls through
    rom[13] = enc_b(3'b001, 5'd3, 5'd7, 13'd8);
    rom[14] = enc_i(5'd10, 5'd9, 12'h7ff);
    // jal to 0x14c
    rom[15] = enc_j(5'd11, 21'd16);
    rom[16] = enc_i(5'd12, 5'd0, 12'h001);
    rom[17] = enc_i(5'd13, 5'd0, 12'h002);
    rom[18] = enc_i(5'd14, 5'd0, 12'h003);
    rom[19] = enc_r(7'b0000000, 3'b100, 5'd12, 5'd11, 5'd10);
    // back to back, needs the write bypass
    rom[20] = enc_r(7'b0000000, 3'b000, 5'd13, 5'd12, 5'd12);
    // jal to 0x15a, halfword aligned only
    rom[21] = enc_j(5'd14, 21'd6);
    rom[22] = enc_i(5'd15, 5'd0, 12'h333);
    rom[23] = enc_i(5'd16, 5'd0, 12'h444);
    for (int i = 24; i < 32; i++) begin
      rom[i] = fill_word(rv_core_pkg::RESET_PC + 32'(i) * 32'd4);
    end
  end

  // rom window covers 0x100..0x17f
  always_comb begin
    if (ibus_req.addr[31:7] == rv_core_pkg::RESET_PC[31:7]) begin
      rdata = rom[ibus_req.addr[6:2]];
    end else begin
      rdata = fill_word(ibus_req.addr);
    end
  end

  // busy roughly one cycle in four, top lcg bits
  always @(posedge CLK) begin
    #1;
    lcg_state = lcg_next(lcg_state);
    busy_q    = nRST && (lcg_state[31:30] == 2'b00);
  end

  assign ibus_rsp = {busy_q, rdata};

endmodule

// ==== bench/core_tb.sv ====
`timescale 1ns/1ps

module core_tb;

  localparam int N_EXP = 17;

  // one expected retirement, rd only checked where a register is written
  typedef struct packed {
    rv_core_pkg::word_t     pc;
    logic                   chk_rd;
    rv_core_pkg::reg_addr_t rd;
    rv_core_pkg::word_t     value;
  } exp_t;

  logic                   CLK;
  logic                   nRST;
  logic                   halt;
  rv_core_pkg::ibus_req_t ibus_req;
  rv_core_pkg::ibus_rsp_t ibus_rsp;
  rv_core_pkg::retire_t   retire;
  logic                   fault;

  exp_t        exp_list [N_EXP];
  exp_t        cur_exp;
  logic [4:0]  idx;
  logic        in_list;
  logic        after_reset = 1'b1;
  logic        timed_out = 1'b0;
  int          errors = 0;
  int          test_err0 = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  string       test_name = "reset";

  clock_gen clk_i (
    .CLK  (CLK),
    .nRST (nRST)
  );

  instr_mem_model mem_i (
    .CLK      (CLK),
    .nRST     (nRST),
    .ibus_req (ibus_req),
    .ibus_rsp (ibus_rsp)
  );

  core_top dut_i (
    .CLK      (CLK),
    .nRST     (nRST),
    .halt     (halt),
    .ibus_req (ibus_req),
    .ibus_rsp (ibus_rsp),
    .retire   (retire),
    .fault    (fault)
  );

  // worked out by hand from the program in the memory model
  initial begin
    exp_list[0]  = '{32'h0000_0100, 1'b1, 5'd1,  32'h1234_5000};
    exp_list[1]  = '{32'h0000_0104, 1'b1, 5'd2,  32'h0000_0678};
    exp_list[2]  = '{32'h0000_0108, 1'b1, 5'd3,  32'h1234_5678};
    exp_list[3]  = '{32'h0000_010c, 1'b1, 5'd4,  32'hffff_ffff};
    exp_list[4]  = '{32'h0000_0110, 1'b1, 5'd5,  32'hedcb_a987};
    exp_list[5]  = '{32'h0000_0114, 1'b1, 5'd6,  32'h0000_0678};
    exp_list[6]  = '{32'h0000_0118, 1'b1, 5'd7,  32'h1234_5678};
    exp_list[7]  = '{32'h0000_011c, 1'b1, 5'd8,  32'hedcb_b000};
    exp_list[8]  = '{32'h0000_0120, 1'b1, 5'd0,  32'h0000_0000};
    exp_list[9]  = '{32'h0000_0124, 1'b1, 5'd9,  32'h1234_5000};
    exp_list[10] = '{32'h0000_0128, 1'b0, 5'd0,  32'h0000_0000};
    exp_list[11] = '{32'h0000_0134, 1'b0, 5'd0,  32'h0000_0000};
    exp_list[12] = '{32'h0000_0138, 1'b1, 5'd10, 32'h1234_57ff};
    exp_list[13] = '{32'h0000_013c, 1'b1, 5'd11, 32'h0000_0140};
    exp_list[14] = '{32'h0000_014c, 1'b1, 5'd12, 32'h1234_56bf};
    exp_list[15] = '{32'h0000_0150, 1'b1, 5'd13, 32'h2468_ad7e};
    exp_list[16] = '{32'h0000_0154, 1'b1, 5'd14, 32'h0000_0158};
  end

  // addresses behind a taken branch or jal
  function automatic logic in_shadow(input rv_core_pkg::word_t pc);
    case (pc)
      32'h0000_012c, 32'h0000_0130, 32'h0000_0140, 32'h0000_0144,
      32'h0000_0148, 32'h0000_0158, 32'h0000_015c: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  task automatic report_value(input string what, input rv_core_pkg::word_t expected,
      input rv_core_pkg::word_t actual);
    $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, expected, actual);
    errors++;
  endtask

  task automatic report_text(input string msg);
    $display("%s: %s", test_name, msg);
    errors++;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_err0 = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors != test_err0) begin
      tests_failed++;
      $display("test %s: failed, %0d errors", test_name, errors - test_err0);
    end else begin
      $display("test %s: ok", test_name);
    end
  endtask

  task automatic drive_halt(input logic value);
    @(posedge CLK);
    #1;
    halt = value;
  endtask

  task automatic wait_reset_release(input int max_cycles);
    int n;
    n = 0;
    while (!nRST && n < max_cycles) begin
      @(posedge CLK);
      n++;
    end
    if (!nRST) begin
      report_text("reset was never released");
      timed_out = 1'b1;
    end
  endtask

  // whole list retired and core parked in fault
  task automatic wait_program_done(input int max_cycles);
    int n;
    n = 0;
    while (!(int'(idx) == N_EXP && fault) && n < max_cycles) begin
      @(negedge CLK);
      n++;
    end
    if (!(int'(idx) == N_EXP && fault)) begin
      report_text("timed out before the program reached its fault");
      timed_out = 1'b1;
    end
  endtask

  // high only in the first cycle out of reset
  always @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      after_reset <= 1'b1;
    end else begin
      after_reset <= 1'b0;
    end
  end

  // next expected entry, restarts on halt
  always @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      idx <= '0;
    end else if (halt) begin
      idx <= '0;
    end else if (retire.valid && in_list) begin
      idx <= idx + 5'd1;
    end
  end

  assign in_list = (int'(idx) < N_EXP);
  assign cur_exp = in_list ? exp_list[idx] : '0;

  // checks sampled mid-cycle, away from the edge
  a_reset_addr: assert property (@(negedge CLK) disable iff (!nRST)
    after_reset |-> ibus_req.addr == rv_core_pkg::RESET_PC)
    else report_value("first bus address", rv_core_pkg::RESET_PC, ibus_req.addr);

  a_reset_idle: assert property (@(negedge CLK) disable iff (!nRST)
    after_reset |-> !retire.valid && !fault)
    else report_text("retire or fault active right after reset");

  a_retire_known: assert property (@(negedge CLK) disable iff (!nRST)
    retire.valid |-> in_list)
    else report_text("retirement after the last expected instruction");

  a_retire_pc: assert property (@(negedge CLK) disable iff (!nRST)
    retire.valid && in_list |-> retire.pc == cur_exp.pc)
    else report_value("retire pc", cur_exp.pc, retire.pc);

  a_retire_rd: assert property (@(negedge CLK) disable iff (!nRST)
    retire.valid && in_list && cur_exp.chk_rd |-> retire.rd == cur_exp.rd)
    else report_value("retire rd", {27'b0, cur_exp.rd}, {27'b0, retire.rd});

  a_retire_value: assert property (@(negedge CLK) disable iff (!nRST)
    retire.valid && in_list |-> retire.value == cur_exp.value)
    else report_value("retire value", cur_exp.value, retire.value);

  a_no_shadow: assert property (@(negedge CLK) disable iff (!nRST)
    retire.valid |-> !in_shadow(retire.pc))
    else report_text($sformatf("flushed address %h retired", retire.pc));

  // fetch has to hold its request while the bus stalls
  a_busy_hold: assert property (@(negedge CLK) disable iff (!nRST)
    ibus_rsp.busy && !dut_i.redirect.valid && !halt |=> $stable(ibus_req.addr))
    else report_text("fetch address moved while the bus was busy");

  // bus reads requested on every cycle except under halt
  a_read_enable: assert property (@(negedge CLK) disable iff (!nRST)
    ibus_req.ren == !halt)
    else report_value("read enable", {31'b0, !halt}, {31'b0, ibus_req.ren});

  a_fault_quiet: assert property (@(negedge CLK) disable iff (!nRST)
    fault |-> !retire.valid)
    else report_text("retirement while fault is high");

  a_fault_after_jal: assert property (@(negedge CLK) disable iff (!nRST)
    $rose(fault) |-> int'(idx) == N_EXP)
    else report_value("retired count at fault", 32'(N_EXP), {27'b0, idx});

  a_halt_addr: assert property (@(negedge CLK) disable iff (!nRST)
    halt |=> ibus_req.addr == rv_core_pkg::RESET_PC)
    else report_value("address under halt", rv_core_pkg::RESET_PC, ibus_req.addr);

  a_halt_fault: assert property (@(negedge CLK) disable iff (!nRST)
    halt |=> !fault)
    else report_text("fault still high under halt");

  initial begin
    halt = 1'b0;
    start_test("reset");
    wait_reset_release(20);
    // let the first-cycle checks fire
    repeat (2) @(negedge CLK);
    end_test();
    if (!timed_out) begin
      start_test("program");
      wait_program_done(800);
      end_test();
    end
    if (!timed_out) begin
      // core must stay quiet while faulted
      start_test("fault_hold");
      repeat (10) @(negedge CLK);
      end_test();
    end
    if (!timed_out) begin
      start_test("halt_restart");
      drive_halt(1'b1);
      repeat (3) @(posedge CLK);
      drive_halt(1'b0);
      wait_program_done(800);
      end_test();
    end
    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
hdl/rv_core_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/register_file.sv
hdl/core_top.sv
bench/clock_gen.sv
bench/instr_mem_model.sv
bench/core_tb.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: compile run clean

compile:
	verilator --binary --assert --top-module core_tb -f tb.f --Mdir obj_dir -o core_tb

run: compile
	-./obj_dir/core_tb > $(LOG) 2>&1
	@cat $(LOG)
	@! grep -q "SIMULATION FAILED" $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
